//--- src/dbg_wb_pkg.sv
// Debug port to Wishbone bridge shared definitions
// Widths, access codes, request struct, FSM states and RAM geometry

package dbg_wb_pkg;

  ////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////

  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  // One select bit per byte lane
  localparam int SEL_W     = DATA_W / 8;
  localparam int SIZE_W    = 3;
  localparam int ERR_CNT_W = 8;
  // Byte order bit sits above the error count
  localparam int STATUS_W  = ERR_CNT_W + 1;

  ////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////

  // Byte address of a debug access
  typedef logic [ADDR_W-1:0]    dbg_addr_t;
  // Short write words are upper-justified
  typedef logic [DATA_W-1:0]    dbg_data_t;
  typedef logic [SEL_W-1:0]     dbg_sel_t;
  typedef logic [SIZE_W-1:0]    dbg_size_t;
  // Saturating bus error count
  typedef logic [ERR_CNT_W-1:0] err_cnt_t;

  // One debug request as presented on the TCK side
  typedef struct packed {
    dbg_addr_t addr;
    dbg_data_t wdata;
    dbg_size_t size;
    logic      rd_wrn;
  } dbg_req_t;

  // Wishbone cycle FSM
  typedef enum logic {
    WB_IDLE,
    WB_XFER
  } wb_state_e;

  // Access size codes, every other code is a full word
  localparam dbg_size_t SIZE_BYTE = 3'd1;
  localparam dbg_size_t SIZE_HALF = 3'd2;

  ////////////////////////////////////////////////////////////////////
  // Target RAM
  ////////////////////////////////////////////////////////////////////

  localparam int RAM_WORDS = 256;
  localparam int RAM_AW    = 8;
  // First byte address outside the RAM
  localparam dbg_addr_t RAM_LIMIT = dbg_addr_t'(RAM_WORDS * 4);

endpackage

//--- src/dbg_lane_steer.sv
// Byte lane steering between the debug word and the Wishbone data bus
// Byte selects and data placement follow the run-time byte order

`timescale 1ns/1ns

module dbg_lane_steer (
  input  logic                  big_endian_i,
  input  dbg_wb_pkg::dbg_size_t size_i,
  input  logic [1:0]            addr_lo_i,
  input  dbg_wb_pkg::dbg_data_t wdata_i,
  input  dbg_wb_pkg::dbg_sel_t  rd_sel_i,
  input  dbg_wb_pkg::dbg_data_t wb_rdata_i,
  output dbg_wb_pkg::dbg_sel_t  sel_o,
  output dbg_wb_pkg::dbg_data_t wdata_o,
  output dbg_wb_pkg::dbg_data_t rdata_o
);
  import dbg_wb_pkg::*;

  // Lane numbers counted from the least significant byte
  logic [1:0] byte_lane;
  logic       half_hi;
  // Debug byte or halfword copied onto every lane it could use
  dbg_data_t  wr_repl;
  // Lowest selected lane of the latched read
  logic [1:0] rd_lane;
  dbg_data_t  rd_shift;

  ////////////////////////////////////////////////////////////////////
  // Select decode
  ////////////////////////////////////////////////////////////////////

  // Big endian puts the lowest address in the top lane
  assign byte_lane = big_endian_i ? ~addr_lo_i : addr_lo_i;
  assign half_hi   = big_endian_i ? ~addr_lo_i[1] : addr_lo_i[1];

  always_comb begin
    case (size_i)
      SIZE_BYTE: sel_o = dbg_sel_t'(1) << byte_lane;
      SIZE_HALF: sel_o = half_hi ? 4'b1100 : 4'b0011;
      // Word and undefined sizes
      default:   sel_o = 4'b1111;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // Write path
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    case (size_i)
      SIZE_BYTE: wr_repl = {4{wdata_i[31:24]}};
      SIZE_HALF: wr_repl = {2{wdata_i[31:16]}};
      default:   wr_repl = wdata_i;
    endcase
  end

  // Unselected lanes go out as zero
  always_comb begin
    for (int i = 0; i < SEL_W; i++) begin
      wdata_o[8*i +: 8] = sel_o[i] ? wr_repl[8*i +: 8] : 8'h00;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    casez (rd_sel_i)
      4'b???1: rd_lane = 2'd0;
      4'b??10: rd_lane = 2'd1;
      4'b?100: rd_lane = 2'd2;
      default: rd_lane = 2'd3;
    endcase
  end

  // Move the selected lanes down to bit 0
  assign rd_shift = wb_rdata_i >> {rd_lane, 3'b000};

  // Clear the lanes that were not part of the access
  always_comb begin
    case (rd_sel_i)
      4'b0011,
      4'b1100: rdata_o = {16'h0000, rd_shift[15:0]};
      4'b0001,
      4'b0010,
      4'b0100,
      4'b1000: rdata_o = {24'h000000, rd_shift[7:0]};
      default: rdata_o = rd_shift;
    endcase
  end

endmodule

//--- src/dbg_wb_bridge.sv
// Debug request to Wishbone single-cycle bridge
// TCK-side request latch, toggle handshake across clocks, WB cycle FSM

`timescale 1ns/1ns

module dbg_wb_bridge (
  input  logic                  tck_i,
  input  logic                  wb_clk_i,
  input  logic                  rst_i,
  input  dbg_wb_pkg::dbg_req_t  req_i,
  input  logic                  strobe_i,
  input  logic                  big_endian_i,
  input  dbg_wb_pkg::dbg_data_t wb_dat_i,
  input  logic                  wb_ack_i,
  input  logic                  wb_err_i,
  output logic                  rdy_o,
  output dbg_wb_pkg::dbg_data_t data_o,
  output logic                  err_o,
  output logic                  done_err_o,
  output dbg_wb_pkg::dbg_addr_t wb_adr_o,
  output dbg_wb_pkg::dbg_data_t wb_dat_o,
  output dbg_wb_pkg::dbg_sel_t  wb_sel_o,
  output logic                  wb_we_o,
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o
);
  import dbg_wb_pkg::*;

  logic      accept;
  dbg_sel_t  sel_dec;
  dbg_data_t wdat_steer;
  dbg_data_t rdat_steer;

  // Start toggle, TCK side and its WB synchronizer
  logic      str_tgl;
  logic      str_wb1;
  logic      str_wb2;
  logic      str_wb2q;
  logic      start_seen;

  // Completion toggle, WB side and its TCK synchronizer
  logic      done_tgl;
  logic      done_tck1;
  logic      done_tck2;
  logic      done_tck2q;
  logic      done_edge;

  wb_state_e state_q;
  wb_state_e state_d;
  logic      xfer_end;

  // Live request in, latched select and bus data for the read path
  dbg_lane_steer u_steer (
    .big_endian_i (big_endian_i),
    .size_i       (req_i.size),
    .addr_lo_i    (req_i.addr[1:0]),
    .wdata_i      (req_i.wdata),
    .rd_sel_i     (wb_sel_o),
    .wb_rdata_i   (wb_dat_i),
    .sel_o        (sel_dec),
    .wdata_o      (wdat_steer),
    .rdata_o      (rdat_steer)
  );

  ////////////////////////////////////////////////////////////////////
  // TCK domain
  ////////////////////////////////////////////////////////////////////

  assign accept    = strobe_i & rdy_o;
  assign done_edge = done_tck2 ^ done_tck2q;

  // Bus fields held for the whole WB cycle
  always_ff @(posedge tck_i) begin
    if (accept) begin
      wb_adr_o <= req_i.addr;
      wb_sel_o <= sel_dec;
      wb_we_o  <= ~req_i.rd_wrn;
      // Reads leave the old write data alone
      if (!req_i.rd_wrn) begin
        wb_dat_o <= wdat_steer;
      end
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      str_tgl    <= 1'b0;
      done_tck1  <= 1'b0;
      done_tck2  <= 1'b0;
      done_tck2q <= 1'b0;
      rdy_o      <= 1'b1;
      done_err_o <= 1'b0;
    end else begin
      done_tck1  <= done_tgl;
      done_tck2  <= done_tck1;
      done_tck2q <= done_tck2;
      // err_o is stable once the toggle has crossed
      done_err_o <= done_edge & err_o;
      if (accept) begin
        str_tgl <= ~str_tgl;
        rdy_o   <= 1'b0;
      end else if (done_edge) begin
        rdy_o <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // WB domain
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      str_wb1  <= 1'b0;
      str_wb2  <= 1'b0;
      str_wb2q <= 1'b0;
    end else begin
      str_wb1  <= str_tgl;
      str_wb2  <= str_wb1;
      str_wb2q <= str_wb2;
    end
  end

  assign start_seen = str_wb2 ^ str_wb2q;
  assign xfer_end   = wb_cyc_o & (wb_ack_i | wb_err_i);

  // Cycle opens in the same clock the start toggle is seen
  always_comb begin
    state_d  = state_q;
    wb_cyc_o = 1'b0;
    wb_stb_o = 1'b0;
    case (state_q)
      WB_IDLE: begin
        wb_cyc_o = start_seen;
        wb_stb_o = start_seen;
        // Single-clock answer stays in idle
        if (start_seen && !xfer_end) begin
          state_d = WB_XFER;
        end
      end
      WB_XFER: begin
        wb_cyc_o = 1'b1;
        wb_stb_o = 1'b1;
        if (xfer_end) begin
          state_d = WB_IDLE;
        end
      end
      default: state_d = WB_IDLE;
    endcase
  end

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q  <= WB_IDLE;
      done_tgl <= 1'b0;
      err_o    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (xfer_end) begin
        done_tgl <= ~done_tgl;
        err_o    <= wb_err_i;
      end
    end
  end

  // Read word captured only on an acked read
  always_ff @(posedge wb_clk_i) begin
    if (xfer_end && wb_ack_i && !wb_we_o) begin
      data_o <= rdat_steer;
    end
  end

endmodule

//--- src/dbg_bridge_cfg.sv
// Bridge configuration and status register in the TCK domain
// Holds the byte order bit and counts bus errors

`timescale 1ns/1ns

module dbg_bridge_cfg (
  input  logic                              tck_i,
  input  logic                              rst_i,
  input  logic                              cfg_wr_i,
  input  logic                              cfg_dat_i,
  input  logic                              done_err_i,
  output logic                              big_endian_o,
  output logic [dbg_wb_pkg::STATUS_W-1:0]   status_o
);
  import dbg_wb_pkg::*;

  err_cnt_t err_cnt;
  logic     cnt_full;

  ////////////////////////////////////////////////////////////////////
  // Byte order
  ////////////////////////////////////////////////////////////////////

  // Big endian out of reset
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      big_endian_o <= 1'b1;
    end else if (cfg_wr_i) begin
      big_endian_o <= cfg_dat_i;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Error counter
  ////////////////////////////////////////////////////////////////////

  // Counter sticks at its top value
  assign cnt_full = &err_cnt;

  // Any config write restarts the count
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      err_cnt <= '0;
    end else if (cfg_wr_i) begin
      err_cnt <= '0;
    end else if (done_err_i && !cnt_full) begin
      err_cnt <= err_cnt + 1'b1;
    end
  end

  // Bit 8 byte order, bits 7..0 error count
  assign status_o = {big_endian_o, err_cnt};

endmodule

//--- src/dbg_wb_ram.sv
// Wishbone RAM slave with per-byte writes
// One wait state per access, error answer outside the RAM range

`timescale 1ns/1ns

module dbg_wb_ram (
  input  logic                  wb_clk_i,
  input  logic                  rst_i,
  input  dbg_wb_pkg::dbg_addr_t wb_adr_i,
  input  dbg_wb_pkg::dbg_data_t wb_dat_i,
  input  dbg_wb_pkg::dbg_sel_t  wb_sel_i,
  input  logic                  wb_we_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  output dbg_wb_pkg::dbg_data_t wb_dat_o,
  output logic                  wb_ack_o,
  output logic                  wb_err_o
);
  import dbg_wb_pkg::*;

  dbg_data_t         mem [RAM_WORDS];
  logic [RAM_AW-1:0] word_idx;
  logic              req;
  logic              in_range;
  // High in the second clock of a strobe
  logic              wait_q;
  logic              resp;

  assign req      = wb_cyc_i & wb_stb_i;
  assign word_idx = wb_adr_i[RAM_AW+1:2];
  assign in_range = wb_adr_i < RAM_LIMIT;

  ////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////

  // Clears itself after the answer so back-to-back cycles wait again
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= req & ~wait_q;
    end
  end

  assign resp     = req & wait_q;
  assign wb_ack_o = resp & in_range;
  // Out of range answers err and never writes
  assign wb_err_o = resp & ~in_range;

  ////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////

  // Read word fetched during the wait clock
  always_ff @(posedge wb_clk_i) begin
    if (wb_ack_o && wb_we_i) begin
      for (int i = 0; i < SEL_W; i++) begin
        if (wb_sel_i[i]) begin
          mem[word_idx][8*i +: 8] <= wb_dat_i[8*i +: 8];
        end
      end
    end
    wb_dat_o <= mem[word_idx];
  end

endmodule

//--- src/dbg_wb_top.sv
// Debug bridge top level
// Configuration register, Wishbone bridge and target RAM

`timescale 1ns/1ns

module dbg_wb_top (
  input  logic                            tck_i,
  input  logic                            wb_clk_i,
  input  logic                            rst_i,
  input  dbg_wb_pkg::dbg_req_t            req_i,
  input  logic                            strobe_i,
  input  logic                            cfg_wr_i,
  input  logic                            cfg_dat_i,
  output logic                            rdy_o,
  output dbg_wb_pkg::dbg_data_t           data_o,
  output logic                            err_o,
  output logic [dbg_wb_pkg::STATUS_W-1:0] status_o
);
  import dbg_wb_pkg::*;

  // Config to bridge
  logic      big_endian;
  logic      done_err;

  // Wishbone bus between bridge and RAM
  dbg_addr_t wb_adr;
  dbg_data_t wb_dat_m2s;
  dbg_data_t wb_dat_s2m;
  dbg_sel_t  wb_sel;
  logic      wb_we;
  logic      wb_cyc;
  logic      wb_stb;
  logic      wb_ack;
  logic      wb_err;

  dbg_bridge_cfg u_cfg (
    .tck_i        (tck_i),
    .rst_i        (rst_i),
    .cfg_wr_i     (cfg_wr_i),
    .cfg_dat_i    (cfg_dat_i),
    .done_err_i   (done_err),
    .big_endian_o (big_endian),
    .status_o     (status_o)
  );

  dbg_wb_bridge u_bridge (
    .tck_i        (tck_i),
    .wb_clk_i     (wb_clk_i),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .strobe_i     (strobe_i),
    .big_endian_i (big_endian),
    .wb_dat_i     (wb_dat_s2m),
    .wb_ack_i     (wb_ack),
    .wb_err_i     (wb_err),
    .rdy_o        (rdy_o),
    .data_o       (data_o),
    .err_o        (err_o),
    .done_err_o   (done_err),
    .wb_adr_o     (wb_adr),
    .wb_dat_o     (wb_dat_m2s),
    .wb_sel_o     (wb_sel),
    .wb_we_o      (wb_we),
    .wb_cyc_o     (wb_cyc),
    .wb_stb_o     (wb_stb)
  );

  dbg_wb_ram u_ram (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_m2s),
    .wb_sel_i (wb_sel),
    .wb_we_i  (wb_we),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_dat_o (wb_dat_s2m),
    .wb_ack_o (wb_ack),
    .wb_err_o (wb_err)
  );

endmodule

//--- bench/tb_dbg_wb.sv
// Testbench for the debug to Wishbone bridge top level
// Runs file-driven accesses, config writes and status checks

`timescale 1ns/1ns

module tb_dbg_wb;
  import dbg_wb_pkg::*;

  // DUT inputs
  logic     tck_i;
  logic     wb_clk_i;
  logic     rst_i;
  dbg_req_t req_i;
  logic     strobe_i;
  logic     cfg_wr_i;
  logic     cfg_dat_i;

  // DUT outputs
  logic                rdy_o;
  dbg_data_t           data_o;
  logic                err_o;
  logic [STATUS_W-1:0] status_o;

  // Stimulus file fields
  int                  fd;
  int                  code;
  int                  line_no;
  logic [8*200-1:0]    line_buf;
  byte                 op;
  dbg_size_t           f_size;
  dbg_addr_t           f_addr;
  dbg_data_t           f_data;
  dbg_data_t           f_exp_data;
  logic                f_exp_err;
  string               name;

  dbg_wb_top uut (
    .tck_i     (tck_i),
    .wb_clk_i  (wb_clk_i),
    .rst_i     (rst_i),
    .req_i     (req_i),
    .strobe_i  (strobe_i),
    .cfg_wr_i  (cfg_wr_i),
    .cfg_dat_i (cfg_dat_i),
    .rdy_o     (rdy_o),
    .data_o    (data_o),
    .err_o     (err_o),
    .status_o  (status_o)
  );

  ////////////////////////////////////////////////////////////////////
  // Clocks
  ////////////////////////////////////////////////////////////////////

  // Bus clock, 4 ns
  initial begin
    wb_clk_i = 1'b0;
    forever #2 wb_clk_i = ~wb_clk_i;
  end

  // Debug clock, 10 ns
  initial begin
    tck_i = 1'b0;
    forever #5 tck_i = ~tck_i;
  end

  ////////////////////////////////////////////////////////////////////
  // Checks and failure
  ////////////////////////////////////////////////////////////////////

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "testbench stopped at first error");
  endtask

  task automatic check_data(input string tname, input dbg_data_t exp, input dbg_data_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail %s: expected %h, actual %h", tname, exp, act));
    end
  endtask

  task automatic check_err(input string tname, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail %s: expected err %b, actual %b", tname, exp, act));
    end
  endtask

  task automatic check_status(input string tname, input logic [STATUS_W-1:0] exp,
                              input logic [STATUS_W-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail %s: expected status %h, actual %h", tname, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Bus operations
  ////////////////////////////////////////////////////////////////////

  // Outputs sampled on the falling edge, away from the tck updates
  task automatic wait_ready(input string tname);
    int cycles;
    cycles = 0;
    @(negedge tck_i);
    while (!rdy_o && cycles < 200) begin
      @(negedge tck_i);
      cycles++;
    end
    if (!rdy_o) begin
      stop_on_error($sformatf("%s: bridge never became ready within 200 tck cycles", tname));
    end
  endtask

  // One request, optionally followed by a second strobe while busy
  task automatic run_access(input string tname, input logic rd, input dbg_size_t size,
                            input dbg_addr_t addr, input dbg_data_t data,
                            input logic busy_strobe);
    dbg_req_t req;
    req.addr   = addr;
    req.wdata  = data;
    req.size   = size;
    req.rd_wrn = rd;
    @(posedge tck_i);
    req_i    <= req;
    strobe_i <= 1'b1;
    // Accepted on this edge
    @(posedge tck_i);
    strobe_i <= 1'b0;
    if (busy_strobe) begin
      // Same address, inverted data, must never reach the RAM
      req.wdata = ~data;
      @(posedge tck_i);
      req_i    <= req;
      strobe_i <= 1'b1;
      @(negedge tck_i);
      if (rdy_o) begin
        stop_on_error($sformatf("%s: bridge ready too soon for the busy strobe", tname));
      end
      @(posedge tck_i);
      strobe_i <= 1'b0;
    end
    wait_ready(tname);
  endtask

  task automatic config_write(input logic big_endian);
    @(posedge tck_i);
    cfg_wr_i  <= 1'b1;
    cfg_dat_i <= big_endian;
    @(posedge tck_i);
    cfg_wr_i  <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    rst_i     = 1'b1;
    req_i     = '0;
    strobe_i  = 1'b0;
    cfg_wr_i  = 1'b0;
    cfg_dat_i = 1'b0;
    line_no   = 0;

    // Reset for 5 bus clocks
    repeat (5) @(posedge wb_clk_i);
    rst_i <= 1'b0;
    repeat (2) @(posedge tck_i);
    @(negedge tck_i);
    if (!rdy_o) begin
      stop_on_error("bridge not ready after reset");
    end
    check_err("reset err_o", 1'b0, err_o);
    check_status("reset status", 9'h100, status_o);

    fd = $fopen("bench/dbg_wb_input.txt", "r");
    if (fd == 0) begin
      stop_on_error("cannot open bench/dbg_wb_input.txt");
    end

    code = $fscanf(fd, " %c", op);
    while (code == 1) begin
      line_no++;
      if (op == "#") begin
        // Comment line, skip the rest
        code = $fgets(line_buf, fd);
      end else begin
        code = $fscanf(fd, "%h %h %h %h %h", f_size, f_addr, f_data, f_exp_data, f_exp_err);
        if (code != 5) begin
          stop_on_error($sformatf("malformed stimulus on line %0d", line_no));
        end
        name = $sformatf("line %0d %c %h", line_no, op, f_addr);
        case (op)
          "W", "B": begin
            run_access(name, 1'b0, f_size, f_addr, f_data, op == "B");
            check_err(name, f_exp_err, err_o);
          end
          "R": begin
            run_access(name, 1'b1, f_size, f_addr, f_data, 1'b0);
            check_err(name, f_exp_err, err_o);
            // Read data holds its old value after an error
            if (!f_exp_err) begin
              check_data(name, f_exp_data, data_o);
            end
          end
          "C": config_write(f_data[0]);
          "S": begin
            // One more edge lets a pending error pulse reach the count
            @(posedge tck_i);
            @(negedge tck_i);
            check_status(name, f_exp_data[STATUS_W-1:0], status_o);
          end
          default: begin
            stop_on_error($sformatf("unknown operation %c on line %0d", op, line_no));
          end
        endcase
      end
      code = $fscanf(fd, " %c", op);
    end
    $fclose(fd);

    $display("** PASS **");
    $finish;
  end

endmodule

//--- bench/dbg_wb_input.txt
# op size addr data exp_data exp_err, hex; W write, R read, B write plus a strobe while busy
# C config write with big_endian in data bit 0, S status compared with exp_data
S 0 00000000 00000000 00000100 0
W 4 00000000 11223344 00000000 0
W 4 00000010 a5a5a5a5 00000000 0
W 4 000003fc deadbeef 00000000 0
R 4 00000000 00000000 11223344 0
R 4 00000010 00000000 a5a5a5a5 0
R 4 000003fc 00000000 deadbeef 0
W 4 00000020 00000000 00000000 0
W 1 00000020 ab000000 00000000 0
W 1 00000021 cd000000 00000000 0
W 2 00000022 12340000 00000000 0
R 4 00000020 00000000 abcd1234 0
R 1 00000021 00000000 000000cd 0
R 2 00000022 00000000 00001234 0
C 0 00000000 00000000 00000000 0
S 0 00000000 00000000 00000000 0
W 4 00000030 00000000 00000000 0
W 1 00000030 ab000000 00000000 0
W 1 00000031 cd000000 00000000 0
W 2 00000032 12340000 00000000 0
R 4 00000030 00000000 1234cdab 0
R 1 00000031 00000000 000000cd 0
R 1 00000020 00000000 00000034 0
R 4 00000400 00000000 00000000 1
W 4 00000800 12345678 00000000 1
S 0 00000000 00000000 00000002 0
C 0 00000000 00000001 00000000 0
S 0 00000000 00000000 00000100 0
R 4 00000000 00000000 11223344 0
B 4 00000040 cafef00d 00000000 0
R 4 00000040 00000000 cafef00d 0

//--- filelist.f
src/dbg_wb_pkg.sv
src/dbg_lane_steer.sv
src/dbg_wb_bridge.sv
src/dbg_bridge_cfg.sv
src/dbg_wb_ram.sv
src/dbg_wb_top.sv
bench/tb_dbg_wb.sv

//--- Bender.yml
package:
  name: dbg_wb_bridge

dependencies: {}

sources:
  # Package first, then the RTL in compile order
  - files:
      - src/dbg_wb_pkg.sv
      - src/dbg_lane_steer.sv
      - src/dbg_wb_bridge.sv
      - src/dbg_bridge_cfg.sv
      - src/dbg_wb_ram.sv
      - src/dbg_wb_top.sv
  - target: simulation
    files:
      - bench/tb_dbg_wb.sv
